//--- verilog/l2_emu_pkg.sv
package l2_emu_pkg;

  // Physical address and data widths
  localparam int unsigned ADDR_W  = 32;
  localparam int unsigned DW_W    = 64;
  localparam int unsigned LINE_DW = 4;
  localparam int unsigned LINE_W  = DW_W * LINE_DW;

  // Address split, byte offset inside the line is bits 4 to 0
  localparam int unsigned LINE_OFF_W = 5;
  localparam int unsigned DW_SEL_LSB = 3;
  localparam int unsigned DW_SEL_W   = $clog2(LINE_DW);

  // Line memory, index is bits 10 to 5
  localparam int unsigned MEM_LINES = 64;
  localparam int unsigned MEM_IDX_W = $clog2(MEM_LINES);

  // Request buffer
  localparam int unsigned BUF_LEN   = 3;
  localparam int unsigned BUF_IDX_W = 2;

  // Tag directory, set is bits 7 to 5 and tag is bits 31 to 8
  localparam int unsigned TAG_SETS = 8;
  localparam int unsigned SET_W    = $clog2(TAG_SETS);
  localparam int unsigned TAG_LSB  = LINE_OFF_W + SET_W;
  localparam int unsigned TAG_W    = ADDR_W - TAG_LSB;

  // Latency timer loads
  localparam int unsigned HIT_DELAY  = 2;
  localparam int unsigned MISS_DELAY = 6;
  localparam int unsigned TIMER_W    = 3;

  // Write-back buffer tag echoed on write answers
  localparam int unsigned WBB_TAG_W = 4;

  // Request kinds from the L2 arbiter
  typedef enum logic [1:0] {
    REQ_I_READ_LINE  = 2'd0,
    REQ_D_READ_LINE  = 2'd1,
    REQ_D_WRITE_LINE = 2'd2,
    REQ_PTW_LOAD     = 2'd3
  } l2_req_e;

  // Answer kinds towards the L2 arbiter
  typedef enum logic [2:0] {
    ANS_I_LINE_READ    = 3'd0,
    ANS_D_LINE_READ    = 3'd1,
    ANS_D_LINE_WRITTEN = 3'd2,
    ANS_D_WBB_WAKEUP   = 3'd3,
    ANS_PTW_LOAD       = 3'd4
  } l2_ans_e;

endpackage

//--- verilog/l2_req_buffer.sv
`timescale 1ns/10ps

module l2_req_buffer (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 flush_i,
  input  logic                                 req_valid_i,
  input  l2_emu_pkg::l2_req_e                  req_type_i,
  input  logic [l2_emu_pkg::ADDR_W-1:0]        req_paddr_i,
  input  logic [l2_emu_pkg::LINE_W-1:0]        req_line_i,
  input  logic [l2_emu_pkg::WBB_TAG_W-1:0]     req_wbb_tag_i,
  input  logic [l2_emu_pkg::BUF_LEN-1:0]       due_i,
  input  logic                                 take_i,
  output logic                                 req_ready_o,
  output logic                                 accept_o,
  output logic [l2_emu_pkg::BUF_IDX_W-1:0]     load_idx_o,
  output logic [l2_emu_pkg::BUF_LEN-1:0]       valid_o,
  output logic                                 sel_valid_o,
  output logic [l2_emu_pkg::BUF_IDX_W-1:0]     sel_idx_o,
  output l2_emu_pkg::l2_req_e                  sel_type_o,
  output logic [l2_emu_pkg::ADDR_W-1:0]        sel_paddr_o,
  output logic [l2_emu_pkg::LINE_W-1:0]        sel_line_o,
  output logic [l2_emu_pkg::WBB_TAG_W-1:0]     sel_wbb_tag_o
);

  import l2_emu_pkg::*;

  // Entry payload, kept without reset
  l2_req_e              type_q  [BUF_LEN];
  logic [ADDR_W-1:0]    paddr_q [BUF_LEN];
  logic [LINE_W-1:0]    line_q  [BUF_LEN];
  logic [WBB_TAG_W-1:0] wbb_q   [BUF_LEN];
  logic [BUF_LEN-1:0]   valid_q;

  logic [BUF_IDX_W-1:0] free_idx;
  logic                 free_found;
  logic                 due_found;
  logic                 leave;

  // Lowest free slot and lowest due slot, scanned from the top down
  always_comb begin
    free_idx   = '0;
    free_found = 1'b0;
    sel_idx_o  = '0;
    due_found  = 1'b0;
    for (int k = BUF_LEN - 1; k >= 0; k--) begin
      if (!valid_q[k]) begin
        free_idx   = BUF_IDX_W'(k);
        free_found = 1'b1;
      end
      if (due_i[k]) begin
        sel_idx_o = BUF_IDX_W'(k);
        due_found = 1'b1;
      end
    end
  end

  // A flush hides the due entry so nothing is answered from it
  assign sel_valid_o = due_found && !flush_i;
  assign leave       = sel_valid_o && take_i;

  // Ready if a slot is free or the selected slot empties on this edge
  assign req_ready_o = !flush_i && (free_found || leave);
  assign accept_o    = req_valid_i && req_ready_o;
  // When full, the leaving slot is refilled
  assign load_idx_o  = free_found ? free_idx : sel_idx_o;

  // Valid bits: flush first, then refill, then release
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else begin
      for (int k = 0; k < BUF_LEN; k++) begin
        if (accept_o && load_idx_o == BUF_IDX_W'(k)) begin
          valid_q[k] <= 1'b1;
        end else if (leave && sel_idx_o == BUF_IDX_W'(k)) begin
          valid_q[k] <= 1'b0;
        end
      end
    end
  end

  // Payload capture on acceptance, including the write line
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      type_q[load_idx_o]  <= req_type_i;
      paddr_q[load_idx_o] <= req_paddr_i;
      line_q[load_idx_o]  <= req_line_i;
      wbb_q[load_idx_o]   <= req_wbb_tag_i;
    end
  end

  assign valid_o       = valid_q;
  assign sel_type_o    = type_q[sel_idx_o];
  assign sel_paddr_o   = paddr_q[sel_idx_o];
  assign sel_line_o    = line_q[sel_idx_o];
  assign sel_wbb_tag_o = wbb_q[sel_idx_o];

endmodule

//--- verilog/l2_delay_timers.sv
`timescale 1ns/10ps

module l2_delay_timers (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              load_i,
  input  logic [l2_emu_pkg::BUF_IDX_W-1:0]  load_idx_i,
  input  logic                              miss_i,
  input  logic [l2_emu_pkg::BUF_LEN-1:0]    valid_i,
  output logic [l2_emu_pkg::BUF_LEN-1:0]    due_o,
  output logic [l2_emu_pkg::BUF_LEN-1:0]    miss_flags_o
);

  import l2_emu_pkg::*;

  logic [TIMER_W-1:0] cnt_q [BUF_LEN];
  logic [BUF_LEN-1:0] miss_q;
  logic [BUF_LEN-1:0] due_q;

  for (genvar k = 0; k < BUF_LEN; k++) begin : gen_timer
    logic hit_load;

    assign hit_load = load_i && (load_idx_i == BUF_IDX_W'(k));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[k]  <= '0;
        miss_q[k] <= 1'b0;
        due_q[k]  <= 1'b0;
      end else if (hit_load) begin
        // New entry, latency set by the directory lookup
        cnt_q[k]  <= miss_i ? TIMER_W'(MISS_DELAY) : TIMER_W'(HIT_DELAY);
        miss_q[k] <= miss_i;
        due_q[k]  <= 1'b0;
      end else begin
        // Countdown saturates at zero
        if (valid_i[k] && cnt_q[k] != '0) begin
          cnt_q[k] <= cnt_q[k] - 1'b1;
        end
        // Registered due flag adds the lookup cycle
        due_q[k] <= valid_i[k] && (cnt_q[k] == '0);
      end
    end
  end

  // Released or flushed entries are never due
  assign due_o        = due_q & valid_i;
  assign miss_flags_o = miss_q;

endmodule

//--- verilog/l2_tag_dir.sv
`timescale 1ns/10ps

module l2_tag_dir (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           lookup_i,
  input  logic [l2_emu_pkg::ADDR_W-1:0]  paddr_i,
  output logic                           miss_o
);

  import l2_emu_pkg::*;

  logic [TAG_SETS-1:0] valid_q;
  logic [TAG_W-1:0]    tag_q [TAG_SETS];

  logic [SET_W-1:0]    set_idx;
  logic [TAG_W-1:0]    req_tag;

  // Set from bits 7 to 5, tag from bits 31 to 8
  assign set_idx = paddr_i[LINE_OFF_W +: SET_W];
  assign req_tag = paddr_i[TAG_LSB +: TAG_W];

  // Hit only on a valid set holding the same tag
  assign miss_o = !(valid_q[set_idx] && (tag_q[set_idx] == req_tag));

  // Valid bits are control state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (lookup_i && miss_o) begin
      valid_q[set_idx] <= 1'b1;
    end
  end

  // Install on a miss so the next access to the line hits
  always_ff @(posedge clk_i) begin
    if (lookup_i && miss_o) begin
      tag_q[set_idx] <= req_tag;
    end
  end

endmodule

//--- verilog/l2_line_mem.sv
`timescale 1ns/10ps

module l2_line_mem (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [l2_emu_pkg::ADDR_W-1:0]  rd_paddr_i,
  input  logic                           wr_en_i,
  input  logic [l2_emu_pkg::LINE_W-1:0]  wr_line_i,
  output logic [l2_emu_pkg::LINE_W-1:0]  rd_line_o,
  output logic [l2_emu_pkg::DW_W-1:0]    rd_dw_o
);

  import l2_emu_pkg::*;

  logic [LINE_W-1:0]    mem_q [MEM_LINES];
  logic [MEM_IDX_W-1:0] line_idx;
  logic [DW_SEL_W-1:0]  dw_sel;

  // Line index from bits 10 to 5, doubleword from bits 4 to 3
  assign line_idx = rd_paddr_i[LINE_OFF_W +: MEM_IDX_W];
  assign dw_sel   = rd_paddr_i[DW_SEL_LSB +: DW_SEL_W];

  // Memory starts cleared
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < MEM_LINES; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      // Write shares the read address of the selected entry
      mem_q[line_idx] <= wr_line_i;
    end
  end

  // Combinational reads
  assign rd_line_o = mem_q[line_idx];
  assign rd_dw_o   = rd_line_o[dw_sel * DW_W +: DW_W];

endmodule

//--- verilog/l2_ans_ctrl.sv
`timescale 1ns/10ps

module l2_ans_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              sel_valid_i,
  input  l2_emu_pkg::l2_req_e               sel_type_i,
  input  logic [l2_emu_pkg::ADDR_W-1:0]     sel_paddr_i,
  input  logic [l2_emu_pkg::WBB_TAG_W-1:0]  sel_wbb_tag_i,
  input  logic                              sel_miss_i,
  input  logic [l2_emu_pkg::LINE_W-1:0]     mem_line_i,
  input  logic [l2_emu_pkg::DW_W-1:0]       mem_dw_i,
  input  logic                              ans_ready_i,
  output logic                              take_o,
  output logic                              mem_wr_en_o,
  output logic                              ans_valid_o,
  output l2_emu_pkg::l2_ans_e               ans_type_o,
  output logic [l2_emu_pkg::ADDR_W-1:0]     ans_paddr_o,
  output logic [l2_emu_pkg::LINE_W-1:0]     ans_line_o,
  output logic [l2_emu_pkg::DW_W-1:0]       ans_data_o,
  output logic [l2_emu_pkg::WBB_TAG_W-1:0]  ans_wbb_tag_o
);

  import l2_emu_pkg::*;

  typedef enum logic {
    ANS_IDLE,
    ANS_HOLD
  } ans_state_e;

  ans_state_e state_q;
  ans_state_e state_d;

  // Take when the answer slot is empty or drains on this edge
  assign take_o      = sel_valid_i && (state_q == ANS_IDLE || ans_ready_i);
  // Write commits together with the take
  assign mem_wr_en_o = take_o && (sel_type_i == REQ_D_WRITE_LINE);

  always_comb begin
    state_d = state_q;
    if (take_o) begin
      state_d = ANS_HOLD;
    end else if (state_q == ANS_HOLD && ans_ready_i) begin
      state_d = ANS_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ANS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign ans_valid_o = (state_q == ANS_HOLD);

  // Answer fields only change on a take, so they hold under stall
  always_ff @(posedge clk_i) begin
    if (take_o) begin
      ans_paddr_o   <= sel_paddr_i;
      ans_line_o    <= '0;
      ans_data_o    <= '0;
      ans_wbb_tag_o <= '0;
      unique case (sel_type_i)
        REQ_I_READ_LINE: begin
          ans_type_o <= ANS_I_LINE_READ;
          ans_line_o <= mem_line_i;
        end
        REQ_D_READ_LINE: begin
          ans_type_o <= ANS_D_LINE_READ;
          ans_line_o <= mem_line_i;
        end
        REQ_D_WRITE_LINE: begin
          // Missed writes wake up the write-back buffer
          ans_type_o    <= sel_miss_i ? ANS_D_WBB_WAKEUP : ANS_D_LINE_WRITTEN;
          ans_wbb_tag_o <= sel_wbb_tag_i;
        end
        default: begin
          ans_type_o <= ANS_PTW_LOAD;
          ans_data_o <= mem_dw_i;
        end
      endcase
    end
  end

endmodule

//--- verilog/l2_cache_emu.sv
`timescale 1ns/10ps

module l2_cache_emu (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              flush_i,
  // Request channel from the L2 arbiter
  input  logic                              req_valid_i,
  input  l2_emu_pkg::l2_req_e               req_type_i,
  input  logic [l2_emu_pkg::ADDR_W-1:0]     req_paddr_i,
  input  logic [l2_emu_pkg::LINE_W-1:0]     req_line_i,
  input  logic [l2_emu_pkg::WBB_TAG_W-1:0]  req_wbb_tag_i,
  output logic                              req_ready_o,
  // Answer channel to the L2 arbiter
  output logic                              ans_valid_o,
  output l2_emu_pkg::l2_ans_e               ans_type_o,
  output logic [l2_emu_pkg::ADDR_W-1:0]     ans_paddr_o,
  output logic [l2_emu_pkg::LINE_W-1:0]     ans_line_o,
  output logic [l2_emu_pkg::DW_W-1:0]       ans_data_o,
  output logic [l2_emu_pkg::WBB_TAG_W-1:0]  ans_wbb_tag_o,
  input  logic                              ans_ready_i
);

  import l2_emu_pkg::*;

  logic                 accept;
  logic [BUF_IDX_W-1:0] load_idx;
  logic [BUF_LEN-1:0]   entry_valid;
  logic [BUF_LEN-1:0]   due;
  logic [BUF_LEN-1:0]   miss_flags;
  logic                 miss;
  logic                 take;
  logic                 sel_valid;
  logic [BUF_IDX_W-1:0] sel_idx;
  l2_req_e              sel_type;
  logic [ADDR_W-1:0]    sel_paddr;
  logic [LINE_W-1:0]    sel_line;
  logic [WBB_TAG_W-1:0] sel_wbb_tag;
  logic                 sel_miss;
  logic                 mem_wr_en;
  logic [LINE_W-1:0]    mem_line;
  logic [DW_W-1:0]      mem_dw;

  // Miss flag of the entry offered to answer control
  assign sel_miss = miss_flags[sel_idx];

  l2_req_buffer i_req_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .req_valid_i   (req_valid_i),
    .req_type_i    (req_type_i),
    .req_paddr_i   (req_paddr_i),
    .req_line_i    (req_line_i),
    .req_wbb_tag_i (req_wbb_tag_i),
    .due_i         (due),
    .take_i        (take),
    .req_ready_o   (req_ready_o),
    .accept_o      (accept),
    .load_idx_o    (load_idx),
    .valid_o       (entry_valid),
    .sel_valid_o   (sel_valid),
    .sel_idx_o     (sel_idx),
    .sel_type_o    (sel_type),
    .sel_paddr_o   (sel_paddr),
    .sel_line_o    (sel_line),
    .sel_wbb_tag_o (sel_wbb_tag)
  );

  // Lookup at acceptance with the incoming address
  l2_tag_dir i_tag_dir (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .lookup_i (accept),
    .paddr_i  (req_paddr_i),
    .miss_o   (miss)
  );

  l2_delay_timers i_delay_timers (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .load_i       (accept),
    .load_idx_i   (load_idx),
    .miss_i       (miss),
    .valid_i      (entry_valid),
    .due_o        (due),
    .miss_flags_o (miss_flags)
  );

  l2_line_mem i_line_mem (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_paddr_i (sel_paddr),
    .wr_en_i    (mem_wr_en),
    .wr_line_i  (sel_line),
    .rd_line_o  (mem_line),
    .rd_dw_o    (mem_dw)
  );

  l2_ans_ctrl i_ans_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .sel_valid_i   (sel_valid),
    .sel_type_i    (sel_type),
    .sel_paddr_i   (sel_paddr),
    .sel_wbb_tag_i (sel_wbb_tag),
    .sel_miss_i    (sel_miss),
    .mem_line_i    (mem_line),
    .mem_dw_i      (mem_dw),
    .ans_ready_i   (ans_ready_i),
    .take_o        (take),
    .mem_wr_en_o   (mem_wr_en),
    .ans_valid_o   (ans_valid_o),
    .ans_type_o    (ans_type_o),
    .ans_paddr_o   (ans_paddr_o),
    .ans_line_o    (ans_line_o),
    .ans_data_o    (ans_data_o),
    .ans_wbb_tag_o (ans_wbb_tag_o)
  );

endmodule

//--- tb/l2_emu_checker.sv
`timescale 1ns/10ps

module l2_emu_checker (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              flush_i,
  input  logic                              req_valid_i,
  input  logic                              req_ready_i,
  input  l2_emu_pkg::l2_req_e               req_type_i,
  input  logic [l2_emu_pkg::ADDR_W-1:0]     req_paddr_i,
  input  logic [l2_emu_pkg::LINE_W-1:0]     req_line_i,
  input  logic [l2_emu_pkg::WBB_TAG_W-1:0]  req_wbb_tag_i,
  input  logic                              ans_valid_i,
  input  logic                              ans_ready_i,
  input  l2_emu_pkg::l2_ans_e               ans_type_i,
  input  logic [l2_emu_pkg::ADDR_W-1:0]     ans_paddr_i,
  input  logic [l2_emu_pkg::LINE_W-1:0]     ans_line_i,
  input  logic [l2_emu_pkg::DW_W-1:0]       ans_data_i,
  input  logic [l2_emu_pkg::WBB_TAG_W-1:0]  ans_wbb_tag_i,
  output int                                err_cnt_o,
  output int                                ans_cnt_o,
  output int                                pend_cnt_o
);

  import l2_emu_pkg::*;

  typedef struct packed {
    l2_req_e              kind;
    logic [ADDR_W-1:0]    paddr;
    logic [LINE_W-1:0]    line;
    logic [WBB_TAG_W-1:0] wbb;
    logic                 miss;
  } req_t;

  typedef struct packed {
    l2_ans_e              kind;
    logic [ADDR_W-1:0]    paddr;
    logic [LINE_W-1:0]    line;
    logic [DW_W-1:0]      data;
    logic [WBB_TAG_W-1:0] wbb;
  } ans_t;

  // Accepted requests not yet answered
  req_t                pend_q[$];
  // Line memory and tag directory models
  logic [LINE_W-1:0]   mem_m [MEM_LINES];
  logic [TAG_SETS-1:0] tag_vld_m;
  logic [TAG_W-1:0]    tag_m [TAG_SETS];
  // Answer seen on the last stalled edge
  ans_t                held_q;
  logic                hold_q;

  // Expected answer for a request, given the line the memory holds now
  function automatic ans_t ref_answer(input req_t r, input logic [LINE_W-1:0] line);
    ans_t       a;
    logic [1:0] dw;
    a       = '0;
    dw      = r.paddr[4:3];
    a.paddr = r.paddr;
    case (r.kind)
      REQ_I_READ_LINE: begin
        a.kind = ANS_I_LINE_READ;
        a.line = line;
      end
      REQ_D_READ_LINE: begin
        a.kind = ANS_D_LINE_READ;
        a.line = line;
      end
      REQ_D_WRITE_LINE: begin
        a.kind = r.miss ? ANS_D_WBB_WAKEUP : ANS_D_LINE_WRITTEN;
        a.wbb  = r.wbb;
      end
      default: begin
        a.kind = ANS_PTW_LOAD;
        a.data = line[dw * DW_W +: DW_W];
      end
    endcase
    return a;
  endfunction

  // Oldest pending request that the observed answer belongs to
  function automatic int find_match(input l2_ans_e k, input logic [ADDR_W-1:0] pa,
                                    input logic [WBB_TAG_W-1:0] w);
    l2_req_e want;
    case (k)
      ANS_I_LINE_READ: want = REQ_I_READ_LINE;
      ANS_D_LINE_READ: want = REQ_D_READ_LINE;
      ANS_PTW_LOAD:    want = REQ_PTW_LOAD;
      default:         want = REQ_D_WRITE_LINE;
    endcase
    for (int i = 0; i < pend_q.size(); i++) begin
      if (pend_q[i].paddr == pa && pend_q[i].kind == want &&
          (want != REQ_D_WRITE_LINE || pend_q[i].wbb == w)) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic check_field(input string name, input logic [LINE_W-1:0] exp,
                             input logic [LINE_W-1:0] got);
    if (exp !== got) begin
      $display("Fail %s exp %0h got %0h", name, exp, got);
      err_cnt_o++;
    end
  endtask

  task automatic check_held();
    if (!ans_valid_i) begin
      $display("Answer withdrawn while the answer channel was stalled");
      err_cnt_o++;
    end
    check_field("ans_type_o (stalled)", held_q.kind, ans_type_i);
    check_field("ans_paddr_o (stalled)", held_q.paddr, ans_paddr_i);
    check_field("ans_line_o (stalled)", held_q.line, ans_line_i);
    check_field("ans_data_o (stalled)", held_q.data, ans_data_i);
    check_field("ans_wbb_tag_o (stalled)", held_q.wbb, ans_wbb_tag_i);
  endtask

  // Memory effects follow answer order
  task automatic consume_answer();
    int   idx;
    ans_t e;
    ans_cnt_o++;
    idx = find_match(ans_type_i, ans_paddr_i, ans_wbb_tag_i);
    if (idx < 0) begin
      $display("Answer of kind %0d for address %0h matches no pending request",
               ans_type_i, ans_paddr_i);
      err_cnt_o++;
    end else begin
      e = ref_answer(pend_q[idx], mem_m[pend_q[idx].paddr[10:5]]);
      check_field("ans_type_o", e.kind, ans_type_i);
      check_field("ans_paddr_o", e.paddr, ans_paddr_i);
      check_field("ans_line_o", e.line, ans_line_i);
      check_field("ans_data_o", e.data, ans_data_i);
      check_field("ans_wbb_tag_o", e.wbb, ans_wbb_tag_i);
      if (pend_q[idx].kind == REQ_D_WRITE_LINE) begin
        mem_m[pend_q[idx].paddr[10:5]] = pend_q[idx].line;
      end
      pend_q.delete(idx);
    end
  endtask

  // Hit or miss is fixed in acceptance order
  task automatic accept_request();
    req_t       r;
    logic [2:0] set_idx;
    set_idx = req_paddr_i[7:5];
    r.kind  = req_type_i;
    r.paddr = req_paddr_i;
    r.line  = req_line_i;
    r.wbb   = req_wbb_tag_i;
    r.miss  = !(tag_vld_m[set_idx] && tag_m[set_idx] == req_paddr_i[31:8]);
    if (r.miss) begin
      tag_vld_m[set_idx] = 1'b1;
      tag_m[set_idx]     = req_paddr_i[31:8];
    end
    pend_q.push_back(r);
  endtask

  // A flush drops the buffered requests but not a stalled answer
  task automatic flush_pending();
    int   keep;
    req_t r;
    keep = -1;
    if (ans_valid_i && !ans_ready_i) begin
      keep = find_match(ans_type_i, ans_paddr_i, ans_wbb_tag_i);
    end
    if (keep >= 0) begin
      r = pend_q[keep];
    end
    pend_q.delete();
    if (keep >= 0) begin
      pend_q.push_back(r);
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      pend_q.delete();
      for (int i = 0; i < MEM_LINES; i++) begin
        mem_m[i] = '0;
      end
      tag_vld_m  = '0;
      hold_q     = 1'b0;
      err_cnt_o  = 0;
      ans_cnt_o  = 0;
      pend_cnt_o = 0;
    end else begin
      if (hold_q) begin
        check_held();
      end
      hold_q       = ans_valid_i && !ans_ready_i;
      held_q.kind  = ans_type_i;
      held_q.paddr = ans_paddr_i;
      held_q.line  = ans_line_i;
      held_q.data  = ans_data_i;
      held_q.wbb   = ans_wbb_tag_i;
      // Consume before flush and accept on the same edge
      if (ans_valid_i && ans_ready_i) begin
        consume_answer();
      end
      if (flush_i) begin
        flush_pending();
      end
      if (req_valid_i && req_ready_i) begin
        accept_request();
      end
      pend_cnt_o = pend_q.size();
    end
  end

endmodule

//--- tb/tb_l2_cache_emu.sv
`timescale 1ns/10ps

module tb_l2_cache_emu;

  import l2_emu_pkg::*;

  // Requests over all tests: 2 + 3 + 3 + 12 + 6 + 150
  localparam int N_REQ       = 176;
  localparam int CYCLE_LIMIT = 20 * N_REQ + 200;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 flush;
  logic                 req_valid;
  l2_req_e              req_type;
  logic [ADDR_W-1:0]    req_paddr;
  logic [LINE_W-1:0]    req_line;
  logic [WBB_TAG_W-1:0] req_wbb;
  logic                 req_ready;
  logic                 ans_valid;
  l2_ans_e              ans_type;
  logic [ADDR_W-1:0]    ans_paddr;
  logic [LINE_W-1:0]    ans_line;
  logic [DW_W-1:0]      ans_data;
  logic [WBB_TAG_W-1:0] ans_wbb;
  logic                 ans_ready = 1'b1;

  integer               seed = 33857;
  // Own stream for back-pressure
  integer               stall_seed = 33857;
  logic                 stall_en = 1'b0;
  logic [WBB_TAG_W-1:0] wbb_cnt = '0;
  int                   cycle_cnt = 0;
  int                   top_err = 0;
  int                   err_mark = 0;
  int                   chk_err;
  int                   ans_cnt;
  int                   pend_cnt;

  // 4 ns clock
  always #2 clk = ~clk;

  l2_cache_emu DUT (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .flush_i       (flush),
    .req_valid_i   (req_valid),
    .req_type_i    (req_type),
    .req_paddr_i   (req_paddr),
    .req_line_i    (req_line),
    .req_wbb_tag_i (req_wbb),
    .req_ready_o   (req_ready),
    .ans_valid_o   (ans_valid),
    .ans_type_o    (ans_type),
    .ans_paddr_o   (ans_paddr),
    .ans_line_o    (ans_line),
    .ans_data_o    (ans_data),
    .ans_wbb_tag_o (ans_wbb),
    .ans_ready_i   (ans_ready)
  );

  l2_emu_checker i_checker (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .flush_i       (flush),
    .req_valid_i   (req_valid),
    .req_ready_i   (req_ready),
    .req_type_i    (req_type),
    .req_paddr_i   (req_paddr),
    .req_line_i    (req_line),
    .req_wbb_tag_i (req_wbb),
    .ans_valid_i   (ans_valid),
    .ans_ready_i   (ans_ready),
    .ans_type_i    (ans_type),
    .ans_paddr_i   (ans_paddr),
    .ans_line_i    (ans_line),
    .ans_data_i    (ans_data),
    .ans_wbb_tag_i (ans_wbb),
    .err_cnt_o     (chk_err),
    .ans_cnt_o     (ans_cnt),
    .pend_cnt_o    (pend_cnt)
  );

  // Random back-pressure, about half the cycles stalled
  always @(posedge clk) begin
    if (stall_en) begin
      ans_ready <= ($random(stall_seed) & 1) != 0;
    end else begin
      ans_ready <= 1'b1;
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: run not finished within %0d cycles", CYCLE_LIMIT);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [LINE_W-1:0] rand_line();
    logic [LINE_W-1:0] l;
    for (int i = 0; i < LINE_W / 32; i++) begin
      l[i*32 +: 32] = $random(seed);
    end
    return l;
  endfunction

  // Every request gets its own tag so in-flight writes stay apart
  function automatic logic [WBB_TAG_W-1:0] next_wbb();
    wbb_cnt = wbb_cnt + 1'b1;
    return wbb_cnt;
  endfunction

  // Called right after a rising edge, returns on the accepting edge
  task automatic send_req(input l2_req_e kind, input logic [ADDR_W-1:0] paddr,
                          input logic [LINE_W-1:0] line, input logic [WBB_TAG_W-1:0] wbb);
    req_valid <= 1'b1;
    req_type  <= kind;
    req_paddr <= paddr;
    req_line  <= line;
    req_wbb   <= wbb;
    forever begin
      @(negedge clk);
      if (req_ready) begin
        break;
      end
      @(posedge clk);
    end
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  // Four tags over all eight sets, any doubleword, optional idle cycle
  task automatic send_random();
    l2_req_e           kind;
    logic [ADDR_W-1:0] paddr;
    kind  = l2_req_e'($random(seed) & 3);
    paddr = {24'h000100 + 24'($random(seed) & 3), 3'($random(seed)), 2'($random(seed)), 3'b000};
    send_req(kind, paddr, rand_line(), next_wbb());
    repeat ($random(seed) & 1) @(posedge clk);
  endtask

  // Cycles from acceptance until ans_valid rises
  task automatic expect_latency(input int exp);
    int n;
    n = 0;
    forever begin
      @(negedge clk);
      if (ans_valid) begin
        break;
      end
      n++;
    end
    if (n != exp) begin
      $display("Fail ans_valid_o latency exp %0h got %0h", exp, n);
      top_err++;
    end
    @(posedge clk);
  endtask

  // Wait until every accepted request has been answered
  task automatic drain();
    forever begin
      @(negedge clk);
      if (pend_cnt == 0 && !ans_valid) begin
        break;
      end
    end
    @(posedge clk);
  endtask

  task automatic expect_silence(input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk);
      // All entries are free right after the flush edge
      if (n == 0 && !req_ready) begin
        $display("Fail req_ready_o exp %0h got %0h", 1'b1, req_ready);
        top_err++;
      end
      if (ans_valid) begin
        $display("An answer was issued for a flushed request");
        top_err++;
      end
    end
    @(posedge clk);
  endtask

  task automatic end_test(input string name);
    int errs;
    @(negedge clk);
    errs = top_err + chk_err - err_mark;
    $display("%s: %0d errors", name, errs);
    err_mark = top_err + chk_err;
    @(posedge clk);
  endtask

  initial begin
    rst_n     = 1'b0;
    flush     = 1'b0;
    req_valid = 1'b0;
    req_type  = REQ_I_READ_LINE;
    req_paddr = '0;
    req_line  = '0;
    req_wbb   = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (ans_valid || !req_ready) begin
      $display("After reset the DUT is not idle and ready");
      top_err++;
    end
    @(posedge clk);

    // Cold write misses, the read of the same line then hits
    send_req(REQ_D_WRITE_LINE, 32'h0000_1040, rand_line(), next_wbb());
    expect_latency(8);
    drain();
    send_req(REQ_D_READ_LINE, 32'h0000_1040, '0, next_wbb());
    expect_latency(4);
    drain();
    end_test("Test 1 write miss then read hit");

    // Stored line, then doubleword 3 of it and the whole line
    send_req(REQ_D_WRITE_LINE, 32'h0000_2280, rand_line(), next_wbb());
    drain();
    send_req(REQ_PTW_LOAD, 32'h0000_2298, '0, next_wbb());
    drain();
    send_req(REQ_I_READ_LINE, 32'h0000_2288, '0, next_wbb());
    drain();
    end_test("Test 2 PTW load and instruction read");

    // Three cold lines back to back fill the buffer
    send_req(REQ_D_WRITE_LINE, 32'h0003_0000, rand_line(), next_wbb());
    send_req(REQ_D_READ_LINE, 32'h0003_0020, '0, next_wbb());
    send_req(REQ_PTW_LOAD, 32'h0003_0048, '0, next_wbb());
    @(negedge clk);
    if (req_ready) begin
      $display("Fail req_ready_o exp %0h got %0h", 1'b0, req_ready);
      top_err++;
    end
    @(posedge clk);
    drain();
    end_test("Test 3 full buffer");

    stall_en <= 1'b1;
    repeat (12) send_random();
    drain();
    stall_en <= 1'b0;
    end_test("Test 4 random back-pressure");

    // Flush while all three entries wait on a miss
    send_req(REQ_D_READ_LINE, 32'h0005_0000, '0, next_wbb());
    send_req(REQ_D_WRITE_LINE, 32'h0005_0020, rand_line(), next_wbb());
    send_req(REQ_PTW_LOAD, 32'h0005_0048, '0, next_wbb());
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    expect_silence(12);
    send_req(REQ_D_WRITE_LINE, 32'h0005_0020, rand_line(), next_wbb());
    send_req(REQ_D_READ_LINE, 32'h0005_0020, '0, next_wbb());
    send_req(REQ_PTW_LOAD, 32'h0005_0038, '0, next_wbb());
    drain();
    end_test("Test 5 flush");

    stall_en <= 1'b1;
    repeat (150) send_random();
    drain();
    stall_en <= 1'b0;
    end_test("Test 6 long random mix");

    @(negedge clk);
    $display("Summary: %0d answers checked, %0d errors", ans_cnt, top_err + chk_err);
    if (top_err + chk_err == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- l2_cache_emu.f
verilog/l2_emu_pkg.sv
verilog/l2_req_buffer.sv
verilog/l2_delay_timers.sv
verilog/l2_tag_dir.sv
verilog/l2_line_mem.sv
verilog/l2_ans_ctrl.sv
verilog/l2_cache_emu.sv
tb/l2_emu_checker.sv
tb/tb_l2_cache_emu.sv

//--- Bender.yml
package:
  name: l2_cache_emu

sources:
  # Package first, then the blocks and the top level
  - verilog/l2_emu_pkg.sv
  - verilog/l2_req_buffer.sv
  - verilog/l2_delay_timers.sv
  - verilog/l2_tag_dir.sv
  - verilog/l2_line_mem.sv
  - verilog/l2_ans_ctrl.sv
  - verilog/l2_cache_emu.sv
  - target: simulation
    files:
      - tb/l2_emu_checker.sv
      - tb/tb_l2_cache_emu.sv
